// ==== hw/grid_pkg.sv ====
`default_nettype none

package grid_pkg;

    // default grid geometry
    // number of banks, must stay a power of two
    localparam int BANK_N = 4;

    // rows held by each bank
    localparam int BANK_DEPTH = 16;

    // one grid row, 16 cells of 8 bits
    localparam int ROW_WIDTH = 128;

    // host transfer word, same as the APB data bus
    localparam int TX_WIDTH = 32;

    // derived index widths
    localparam int BANK_IDX_WIDTH = $clog2(BANK_N);
    localparam int ROW_ADDR_WIDTH = $clog2(BANK_DEPTH);

    // word index inside one row
    localparam int COL_ADDR_WIDTH = $clog2(ROW_WIDTH / TX_WIDTH);

    // one request toward a bank
    // held stable by the dispatcher until the bank acks
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [ROW_ADDR_WIDTH-1:0] row;
        logic [COL_ADDR_WIDTH-1:0] col;
        logic [TX_WIDTH-1:0]       data;
    } bank_req_t;

    // one response from a bank
    // ack is a single-cycle strobe, data is the addressed word
    typedef struct packed {
        logic                ack;
        logic [TX_WIDTH-1:0] data;
    } bank_rsp_t;

endpackage

`default_nettype wire

// ==== hw/single_port_sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module single_port_sync_ram #(
    parameter int ADDR_WIDTH = 4,
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 128
) (
    input  logic                  clock,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  bank_en,
    input  logic                  write_en,
    input  logic [DATA_WIDTH-1:0] write_data,
    output logic [DATA_WIDTH-1:0] read_data
);

    // storage array, inferred as block RAM
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[addr] <= write_data;
        end
    end

    // registered read, data valid one cycle after bank_en
    always_ff @(posedge clock) begin
        if (bank_en) begin
            read_data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/grid_bank_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_bank_ctrl #(
    parameter int BANK_DEPTH = grid_pkg::BANK_DEPTH,
    parameter int ROW_WIDTH  = grid_pkg::ROW_WIDTH,
    parameter int TX_WIDTH   = grid_pkg::TX_WIDTH
) (
    input  logic                clock,
    input  logic                reset,
    input  grid_pkg::bank_req_t req,
    output grid_pkg::bank_rsp_t rsp
);

    localparam int ROW_ADDR_WIDTH = $clog2(BANK_DEPTH);

    // rows that were written at least once
    logic [BANK_DEPTH-1:0] dirty_list;

    // row buffer and its tag
    logic [ROW_WIDTH-1:0]      row_buf;
    logic [ROW_ADDR_WIDTH-1:0] saved_row;
    logic                      buf_valid;

    // row being fetched, captured when the miss is seen
    logic [ROW_ADDR_WIDTH-1:0] fetch_row;

    // ram side
    logic [ROW_WIDTH-1:0] ram_read_data;
    logic [ROW_WIDTH-1:0] merged_row;

    logic row_hit;
    logic fetch_en;
    logic serve;
    logic write_hit;

    typedef enum logic {
        IDLE,
        FETCH_SAVE
    } fetch_state_t;

    fetch_state_t fetch_state;
    fetch_state_t next_fetch_state;

    // buffered row matches the request
    assign row_hit = buf_valid && (req.row == saved_row);

    // request served straight from the buffer
    assign serve = req.valid && row_hit && (fetch_state == IDLE);

    // miss starts a ram read
    assign fetch_en = req.valid && !row_hit && (fetch_state == IDLE);

    // write-through on a buffered row
    assign write_hit = serve && req.write;

    // buffer with the host word dropped in
    always_comb begin
        merged_row = row_buf;
        merged_row[req.col*TX_WIDTH +: TX_WIDTH] = req.data;
    end

    // one ram per bank, a whole row per entry
    single_port_sync_ram #(
        .ADDR_WIDTH(ROW_ADDR_WIDTH),
        .DEPTH     (BANK_DEPTH),
        .DATA_WIDTH(ROW_WIDTH)
    ) u_row_ram (
        .clock     (clock),
        .addr      (req.row),
        .bank_en   (fetch_en),
        .write_en  (write_hit),
        .write_data(merged_row),
        .read_data (ram_read_data)
    );

    // IDLE -> FETCH_SAVE on a miss, back after one cycle
    always_comb begin
        next_fetch_state = fetch_state;
        case (fetch_state)
            IDLE: begin
                if (fetch_en) begin
                    next_fetch_state = FETCH_SAVE;
                end
            end
            FETCH_SAVE: begin
                next_fetch_state = IDLE;
            end
            default: begin
                next_fetch_state = IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_state <= IDLE;
            buf_valid   <= 1'b0;
            dirty_list  <= '0;
        end else begin
            fetch_state <= next_fetch_state;
            if (fetch_state == FETCH_SAVE) begin
                buf_valid <= 1'b1;
            end
            if (write_hit) begin
                dirty_list[req.row] <= 1'b1;
            end
        end
    end

    // row buffer and tags
    always_ff @(posedge clock) begin
        if (fetch_en) begin
            fetch_row <= req.row;
        end
        if (fetch_state == FETCH_SAVE) begin
            // never-written rows come back as zeros, ram content is ignored
            row_buf   <= dirty_list[fetch_row] ? ram_read_data : '0;
            saved_row <= fetch_row;
        end else if (write_hit) begin
            row_buf <= merged_row;
        end
    end

    // ack is combinational, one cycle per request
    always_comb begin
        rsp.ack  = serve;
        rsp.data = row_buf[req.col*TX_WIDTH +: TX_WIDTH];
    end

endmodule

`default_nettype wire

// ==== hw/grid_apb_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_apb_dispatch #(
    parameter int BANK_N     = grid_pkg::BANK_N,
    parameter int BANK_DEPTH = grid_pkg::BANK_DEPTH,
    parameter int ROW_WIDTH  = grid_pkg::ROW_WIDTH,
    parameter int TX_WIDTH   = grid_pkg::TX_WIDTH
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         paddr,
    input  logic [31:0]         pwdata,
    input  logic [BANK_N-1:0]   bank_ack,
    output grid_pkg::bank_req_t req [BANK_N]
);

    import grid_pkg::*;

    // paddr layout from the low end
    // byte offset, column word, row, bank
    localparam int BYTE_OFS_WIDTH = $clog2(TX_WIDTH / 8);
    localparam int COL_WIDTH      = $clog2(ROW_WIDTH / TX_WIDTH);
    localparam int ROW_WIDTH_A    = $clog2(BANK_DEPTH);
    localparam int BANK_WIDTH     = $clog2(BANK_N);

    localparam int COL_LSB  = BYTE_OFS_WIDTH;
    localparam int ROW_LSB  = COL_LSB + COL_WIDTH;
    localparam int BANK_LSB = ROW_LSB + ROW_WIDTH_A;

    logic [BANK_WIDTH-1:0] sel_bank;
    logic                  setup_phase;
    logic                  issue;

    // one valid per bank, the payload is shared
    logic [BANK_N-1:0] valid_q;
    bank_req_t         cmd_q;
    logic              issued;

    assign sel_bank    = paddr[BANK_LSB +: BANK_WIDTH];
    assign setup_phase = psel && !penable;

    // first setup cycle of a transfer only
    assign issue = setup_phase && !issued;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            issued  <= 1'b0;
        end else begin
            // ack retires the request on this edge
            valid_q <= valid_q & ~bank_ack;
            if (issue) begin
                valid_q[sel_bank] <= 1'b1;
            end
            // rearm once the master deselects
            if (issue) begin
                issued <= 1'b1;
            end else if (!psel) begin
                issued <= 1'b0;
            end
        end
    end

    // transfer payload captured in the setup phase
    always_ff @(posedge clock) begin
        if (issue) begin
            cmd_q <= '{valid: 1'b1,
                       write: pwrite,
                       row:   paddr[ROW_LSB +: ROW_WIDTH_A],
                       col:   paddr[COL_LSB +: COL_WIDTH],
                       data:  pwdata[TX_WIDTH-1:0]};
        end
    end

    // fan out, only the addressed bank sees valid
    always_comb begin
        for (int b = 0; b < BANK_N; b++) begin
            req[b]       = cmd_q;
            req[b].valid = valid_q[b];
        end
    end

endmodule

`default_nettype wire

// ==== hw/grid_rsp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_rsp_collect #(
    parameter int BANK_N   = grid_pkg::BANK_N,
    parameter int TX_WIDTH = grid_pkg::TX_WIDTH
) (
    input  logic                clock,
    input  logic                reset,
    input  grid_pkg::bank_rsp_t rsp [BANK_N],
    output logic [TX_WIDTH-1:0] prdata,
    output logic                pready
);

    logic                ack_any;
    logic [TX_WIDTH-1:0] sel_data;

    // acks are one-hot, so an or-merge picks the acking bank
    always_comb begin
        ack_any  = 1'b0;
        sel_data = '0;
        for (int b = 0; b < BANK_N; b++) begin
            ack_any = ack_any | rsp[b].ack;
            if (rsp[b].ack) begin
                sel_data = sel_data | rsp[b].data;
            end
        end
    end

    // pready follows the ack by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            pready <= 1'b0;
        end else begin
            pready <= ack_any;
        end
    end

    // read data held until the next ack
    always_ff @(posedge clock) begin
        if (ack_any) begin
            prdata <= sel_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/grid_banked_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// the request and response structs are sized from the package defaults,
// so these parameters must be left equal to the grid_pkg values
module grid_banked_mem #(
    parameter int BANK_N     = grid_pkg::BANK_N,
    parameter int BANK_DEPTH = grid_pkg::BANK_DEPTH,
    parameter int ROW_WIDTH  = grid_pkg::ROW_WIDTH,
    parameter int TX_WIDTH   = grid_pkg::TX_WIDTH
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    import grid_pkg::*;

    bank_req_t         bank_req [BANK_N];
    bank_rsp_t         bank_rsp [BANK_N];
    logic [BANK_N-1:0] bank_ack;

    // apb front, one request per transfer
    grid_apb_dispatch #(
        .BANK_N    (BANK_N),
        .BANK_DEPTH(BANK_DEPTH),
        .ROW_WIDTH (ROW_WIDTH),
        .TX_WIDTH  (TX_WIDTH)
    ) u_dispatch (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .bank_ack(bank_ack),
        .req     (bank_req)
    );

    // identical banks
    for (genvar g = 0; g < BANK_N; g++) begin : g_bank
        grid_bank_ctrl #(
            .BANK_DEPTH(BANK_DEPTH),
            .ROW_WIDTH (ROW_WIDTH),
            .TX_WIDTH  (TX_WIDTH)
        ) u_bank (
            .clock(clock),
            .reset(reset),
            .req  (bank_req[g]),
            .rsp  (bank_rsp[g])
        );

        // ack bits back to the dispatcher
        assign bank_ack[g] = bank_rsp[g].ack;
    end

    // TX_WIDTH equals the apb data width
    grid_rsp_collect #(
        .BANK_N  (BANK_N),
        .TX_WIDTH(TX_WIDTH)
    ) u_collect (
        .clock (clock),
        .reset (reset),
        .rsp   (bank_rsp),
        .prdata(prdata),
        .pready(pready)
    );

endmodule

`default_nettype wire

// ==== testbench/grid_banked_mem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_banked_mem_asserts #(
    parameter int BANK_N = grid_pkg::BANK_N
) (
    input logic                clock,
    input logic                reset,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic [BANK_N-1:0]   bank_ack,
    input grid_pkg::bank_req_t bank_req [BANK_N]
);

    logic [BANK_N-1:0] valids;
    logic              psel_seen;

    // valid bits of all bank requests
    always_comb begin
        for (int b = 0; b < BANK_N; b++) begin
            valids[b] = bank_req[b].valid;
        end
    end

    // first psel since reset
    always_ff @(posedge clock) begin
        if (reset) begin
            psel_seen <= 1'b0;
        end else if (psel) begin
            psel_seen <= 1'b1;
        end
    end

    ready_in_access: assert property (@(posedge clock) disable iff (reset)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    ready_one_cycle: assert property (@(posedge clock) disable iff (reset)
        pready |=> !pready)
        else $error("pready held for more than one cycle");

    acks_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(bank_ack))
        else $error("more than one bank acked in the same cycle");

    no_valid_before_psel: assert property (@(posedge clock) disable iff (reset)
        !psel_seen |-> (valids == '0))
        else $error("bank request valid before any psel");

endmodule

bind grid_banked_mem grid_banked_mem_asserts #(
    .BANK_N(BANK_N)
) u_asserts (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .bank_ack(bank_ack),
    .bank_req(bank_req)
);

`default_nettype wire

// ==== testbench/tb_grid_banked_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_grid_banked_mem;

    import grid_pkg::*;

    localparam int CLOCK_PERIOD   = 100;
    localparam int RESET_CYCLES   = 3;
    localparam int WORDS_PER_ROW  = ROW_WIDTH / TX_WIDTH;
    localparam int BYTES_PER_WORD = TX_WIDTH / 8;

    // transfers per test
    // reset reads, single word, row merge, row alternation
    localparam int DIRECTED_COUNT = 2 * BANK_N + 2 + (2 * WORDS_PER_ROW + 1)
                                    + 6 * WORDS_PER_ROW;
    localparam int RANDOM_COUNT   = 300;
    localparam int TRANSFER_COUNT = DIRECTED_COUNT + RANDOM_COUNT;

    // ten cycles per transfer covers a six cycle miss
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TRANSFER_COUNT * 10 + 100;

    logic        clock;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    // reference grid keyed by the byte address of each word
    logic [TX_WIDTH-1:0] ref_grid [logic [31:0]];

    // read in flight for the compare process
    logic        rd_pending = 1'b0;
    logic [31:0] rd_expect  = '0;
    int          reads_issued  = 0;
    int          reads_checked = 0;
    integer      seed = 32'h48a3;

    grid_banked_mem #(
        .BANK_N    (BANK_N),
        .BANK_DEPTH(BANK_DEPTH),
        .ROW_WIDTH (ROW_WIDTH),
        .TX_WIDTH  (TX_WIDTH)
    ) u_grid_banked_mem (
        .clock  (clock),
        .reset  (reset),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // byte address of one word
    // word index counts columns first, then rows, then banks
    function automatic logic [31:0] word_addr(input int bank, input int row, input int col);
        int index;
        index = (bank * BANK_DEPTH + row) * WORDS_PER_ROW + col;
        return index * BYTES_PER_WORD;
    endfunction

    // expected read data is zero for anything never written
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] value;
        value = '0;
        if (ref_grid.exists(addr)) begin
            value = ref_grid[addr];
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    // poll pready once per falling edge
    task automatic wait_ready();
        @(negedge clock);
        while (!pready) begin
            @(negedge clock);
        end
    endtask

    // hold psel through the completing edge and idle for one cycle
    task automatic end_transfer();
        @(negedge clock);
        psel       = 1'b0;
        penable    = 1'b0;
        rd_pending = 1'b0;
        @(negedge clock);
    endtask

    task automatic apb_write(input int bank, input int row, input int col,
                             input logic [31:0] data);
        logic [31:0] addr;
        addr    = word_addr(bank, row, col);
        // setup phase
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clock);
        // access phase
        penable = 1'b1;
        wait_ready();
        ref_grid[addr] = data;
        end_transfer();
    endtask

    task automatic apb_read(input int bank, input int row, input int col);
        logic [31:0] addr;
        addr       = word_addr(bank, row, col);
        rd_expect  = expected_word(addr);
        rd_pending = 1'b1;
        reads_issued++;
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = addr;
        @(negedge clock);
        penable = 1'b1;
        wait_ready();
        end_transfer();
    endtask

    // prdata and pready are both settled by the falling edge
    always @(negedge clock) begin
        if (pready && rd_pending) begin
            check_value("prdata", prdata, rd_expect);
            reads_checked++;
        end
    end

    initial begin
        int          bank;
        int          row;
        int          col;
        logic [31:0] rnd;
        logic [31:0] data;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        // nothing is dirty right after reset
        check_value("pready", 32'(pready), 32'd0);
        for (int b = 0; b < BANK_N; b++) begin
            apb_read(b, 0, b % WORDS_PER_ROW);
            apb_read(b, BANK_DEPTH - 1, WORDS_PER_ROW - 1);
        end

        // single word round trip
        apb_write(0, 7, 1, 32'hcafe_0001);
        apb_read(0, 7, 1);

        // fill one row, then overwrite a middle word
        for (int c = 0; c < WORDS_PER_ROW; c++) begin
            apb_write(1, 5, c, 32'h1100_0000 + c);
        end
        apb_write(1, 5, WORDS_PER_ROW / 2, 32'h5a5a_a5a5);
        for (int c = 0; c < WORDS_PER_ROW; c++) begin
            apb_read(1, 5, c);
        end

        // two rows of one bank so every access misses the buffer
        for (int c = 0; c < WORDS_PER_ROW; c++) begin
            apb_write(BANK_N / 2, 3, c, 32'ha000_0000 | c);
            apb_write(BANK_N / 2, BANK_DEPTH - 5, c, 32'hb000_0000 | c);
            apb_read(BANK_N / 2, 3, c);
            apb_read(BANK_N / 2, BANK_DEPTH - 5, c);
        end
        for (int c = 0; c < WORDS_PER_ROW; c++) begin
            apb_read(BANK_N / 2, 3, c);
            apb_read(BANK_N / 2, BANK_DEPTH - 5, c);
        end

        // random mix over the whole grid
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rnd  = $random(seed);
            data = $random(seed);
            bank = rnd % BANK_N;
            row  = (rnd >> 4) % BANK_DEPTH;
            col  = (rnd >> 12) % WORDS_PER_ROW;
            if (rnd[20]) begin
                apb_write(bank, row, col, data);
            end else begin
                apb_read(bank, row, col);
            end
        end

        // every read must have reached the compare process
        check_value("reads_checked", reads_checked, reads_issued);
        $display("Simulation passed");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("TIMEOUT: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/grid_pkg.sv
hw/single_port_sync_ram.sv
hw/grid_bank_ctrl.sv
hw/grid_apb_dispatch.sv
hw/grid_rsp_collect.sv
hw/grid_banked_mem.sv
testbench/grid_banked_mem_asserts.sv
testbench/tb_grid_banked_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the grid memory testbench with verilator and runs it
# success only if the pass line shows up in the simulator output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module tb_grid_banked_mem -o sim_grid_banked_mem \
    && ./obj_dir/sim_grid_banked_mem | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
